// ==== design/id_ex_reg.sv ====
`timescale 1ns/1ps

module id_ex_reg (
	input  logic             clk,
	input  logic             reset_n,
	input  logic             stall_i,
	input  logic             inst_valid_i,
	input  pipe_pkg::dec_t   dec_i,
	input  isa_pkg::word_t   op1_i,
	input  isa_pkg::word_t   op2_i,
	output pipe_pkg::id_ex_t id_ex_o
);

	pipe_pkg::id_ex_t next;

	// control only passes with a valid instruction
	always_comb begin
		next       = '0;
		next.valid = inst_valid_i;
		next.op1   = op1_i;
		next.op2   = op2_i;
		if (inst_valid_i) begin
			next.aluop  = dec_i.aluop;
			next.alusel = dec_i.alusel;
			next.wreg   = dec_i.wreg;
			next.waddr  = dec_i.waddr;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			id_ex_o <= '0;
		end else if (!stall_i) begin
			id_ex_o <= next;
		end
	end

endmodule

// ==== design/id_stage.sv ====
`timescale 1ns/1ps

module id_stage (
	input  logic             clk,
	input  logic             reset_n,
	input  logic             inst_valid_i,
	input  isa_pkg::inst_t   inst_i,
	input  pipe_pkg::fwd_t   ex_fwd_i,
	input  pipe_pkg::fwd_t   mem_fwd_i,
	input  pipe_pkg::fwd_t   wb_i,
	input  logic             stall_i,
	output pipe_pkg::id_ex_t id_ex_o
);

	pipe_pkg::dec_t dec;
	isa_pkg::word_t rs_data;
	isa_pkg::word_t rt_data;
	isa_pkg::word_t op1;
	isa_pkg::word_t op2;

	inst_decoder u_decoder (
		.inst_i (inst_i),
		.dec_o  (dec)
	);

	regfile u_regfile (
		.clk       (clk),
		.reset_n   (reset_n),
		.wb_i      (wb_i),
		.rs_addr_i (dec.rs_addr),
		.rt_addr_i (dec.rt_addr),
		.rs_data_o (rs_data),
		.rt_data_o (rt_data)
	);

	////////////////////////////////////////
	// operands, rs side then rt side
	////////////////////////////////////////
	operand_select u_op1_sel (
		.read_i     (dec.rs_read),
		.addr_i     (dec.rs_addr),
		.reg_data_i (rs_data),
		.imm_i      (dec.imm),
		.ex_fwd_i   (ex_fwd_i),
		.mem_fwd_i  (mem_fwd_i),
		.operand_o  (op1)
	);

	operand_select u_op2_sel (
		.read_i     (dec.rt_read),
		.addr_i     (dec.rt_addr),
		.reg_data_i (rt_data),
		.imm_i      (dec.imm),
		.ex_fwd_i   (ex_fwd_i),
		.mem_fwd_i  (mem_fwd_i),
		.operand_o  (op2)
	);

	id_ex_reg u_id_ex_reg (
		.clk          (clk),
		.reset_n      (reset_n),
		.stall_i      (stall_i),
		.inst_valid_i (inst_valid_i),
		.dec_i        (dec),
		.op1_i        (op1),
		.op2_i        (op2),
		.id_ex_o      (id_ex_o)
	);

endmodule

// ==== design/inst_decoder.sv ====
`timescale 1ns/1ps

module inst_decoder (
	input  isa_pkg::inst_t inst_i,
	output pipe_pkg::dec_t dec_o
);

	// immediate forms write rt and read only rs
	function automatic pipe_pkg::dec_t i_type(
		input isa_pkg::inst_t    inst,
		input pipe_pkg::aluop_e  op,
		input pipe_pkg::alusel_e sel,
		input logic              sext
	);
		pipe_pkg::dec_t  d;
		isa_pkg::imm16_t imm16;
		imm16     = inst[15:0];
		d         = '0;
		d.aluop   = op;
		d.alusel  = sel;
		d.wreg    = 1'b1;
		d.waddr   = inst.rt;
		d.rs_read = 1'b1;
		d.rs_addr = inst.rs;
		d.rt_addr = inst.rt;
		// logic ops zero extend, arithmetic ops sign extend
		d.imm     = {{16{sext & imm16[15]}}, imm16};
		return d;
	endfunction

	// register forms write rd
	function automatic pipe_pkg::dec_t r_type(
		input isa_pkg::inst_t    inst,
		input pipe_pkg::aluop_e  op,
		input pipe_pkg::alusel_e sel,
		input logic              by_shamt
	);
		pipe_pkg::dec_t d;
		d         = '0;
		d.aluop   = op;
		d.alusel  = sel;
		d.wreg    = 1'b1;
		d.waddr   = inst.rd;
		d.rs_read = !by_shamt;
		d.rs_addr = inst.rs;
		d.rt_read = 1'b1;
		d.rt_addr = inst.rt;
		// shift amount goes out as operand 1 in place of rs
		if (by_shamt) begin
			d.imm = {27'd0, inst.shamt};
		end
		return d;
	endfunction

	////////////////////////////////////////
	// opcode decode
	////////////////////////////////////////
	always_comb begin
		dec_o         = '0;
		dec_o.rs_addr = inst_i.rs;
		dec_o.rt_addr = inst_i.rt;
		case (inst_i.opcode)
			isa_pkg::OP_ORI:
				dec_o = i_type(inst_i, pipe_pkg::ALU_ORI, pipe_pkg::SEL_LOGIC, 1'b0);
			isa_pkg::OP_ANDI:
				dec_o = i_type(inst_i, pipe_pkg::ALU_ANDI, pipe_pkg::SEL_LOGIC, 1'b0);
			isa_pkg::OP_XORI:
				dec_o = i_type(inst_i, pipe_pkg::ALU_XORI, pipe_pkg::SEL_LOGIC, 1'b0);
			isa_pkg::OP_LUI:
				dec_o = i_type(inst_i, pipe_pkg::ALU_LUI, pipe_pkg::SEL_LOGIC, 1'b0);
			isa_pkg::OP_ADDI:
				dec_o = i_type(inst_i, pipe_pkg::ALU_ADDI, pipe_pkg::SEL_ARITH, 1'b1);
			isa_pkg::OP_ADDIU:
				dec_o = i_type(inst_i, pipe_pkg::ALU_ADDIU, pipe_pkg::SEL_ARITH, 1'b1);
			isa_pkg::OP_SLTI:
				dec_o = i_type(inst_i, pipe_pkg::ALU_SLTI, pipe_pkg::SEL_ARITH, 1'b1);
			isa_pkg::OP_SLTIU:
				dec_o = i_type(inst_i, pipe_pkg::ALU_SLTIU, pipe_pkg::SEL_ARITH, 1'b1);

			////////////////////////////////////////
			// SPECIAL, selected by funct
			////////////////////////////////////////
			isa_pkg::OP_SPECIAL: begin
				case (inst_i.funct)
					isa_pkg::FN_AND:
						dec_o = r_type(inst_i, pipe_pkg::ALU_AND, pipe_pkg::SEL_LOGIC, 1'b0);
					isa_pkg::FN_OR:
						dec_o = r_type(inst_i, pipe_pkg::ALU_OR, pipe_pkg::SEL_LOGIC, 1'b0);
					isa_pkg::FN_XOR:
						dec_o = r_type(inst_i, pipe_pkg::ALU_XOR, pipe_pkg::SEL_LOGIC, 1'b0);
					isa_pkg::FN_NOR:
						dec_o = r_type(inst_i, pipe_pkg::ALU_NOR, pipe_pkg::SEL_LOGIC, 1'b0);
					isa_pkg::FN_SLL:
						dec_o = r_type(inst_i, pipe_pkg::ALU_SLL, pipe_pkg::SEL_SHIFT, 1'b1);
					isa_pkg::FN_SRL:
						dec_o = r_type(inst_i, pipe_pkg::ALU_SRL, pipe_pkg::SEL_SHIFT, 1'b1);
					isa_pkg::FN_SRA:
						dec_o = r_type(inst_i, pipe_pkg::ALU_SRA, pipe_pkg::SEL_SHIFT, 1'b1);
					isa_pkg::FN_SLLV:
						dec_o = r_type(inst_i, pipe_pkg::ALU_SLLV, pipe_pkg::SEL_SHIFT, 1'b0);
					isa_pkg::FN_SRLV:
						dec_o = r_type(inst_i, pipe_pkg::ALU_SRLV, pipe_pkg::SEL_SHIFT, 1'b0);
					isa_pkg::FN_SRAV:
						dec_o = r_type(inst_i, pipe_pkg::ALU_SRAV, pipe_pkg::SEL_SHIFT, 1'b0);
					isa_pkg::FN_ADD:
						dec_o = r_type(inst_i, pipe_pkg::ALU_ADD, pipe_pkg::SEL_ARITH, 1'b0);
					isa_pkg::FN_ADDU:
						dec_o = r_type(inst_i, pipe_pkg::ALU_ADDU, pipe_pkg::SEL_ARITH, 1'b0);
					isa_pkg::FN_SUB:
						dec_o = r_type(inst_i, pipe_pkg::ALU_SUB, pipe_pkg::SEL_ARITH, 1'b0);
					isa_pkg::FN_SUBU:
						dec_o = r_type(inst_i, pipe_pkg::ALU_SUBU, pipe_pkg::SEL_ARITH, 1'b0);
					isa_pkg::FN_SLT:
						dec_o = r_type(inst_i, pipe_pkg::ALU_SLT, pipe_pkg::SEL_ARITH, 1'b0);
					isa_pkg::FN_SLTU:
						dec_o = r_type(inst_i, pipe_pkg::ALU_SLTU, pipe_pkg::SEL_ARITH, 1'b0);
					default: begin
						// mult, moves and the like fall out as a bubble
					end
				endcase
			end
			default: begin
				// unknown opcode, NOP with no reads and no write
			end
		endcase
	end

endmodule

// ==== design/isa_pkg.sv ====
package isa_pkg;

	////////////////////////////////////////
	// field widths
	////////////////////////////////////////
	localparam int op_w       = 6;
	localparam int reg_addr_w = 5;
	localparam int shamt_w    = 5;
	localparam int word_w     = 32;
	localparam int imm_w      = 16;

	// general purpose registers, r0 hardwired to zero
	localparam int reg_count  = 32;

	typedef logic [reg_addr_w-1:0] reg_addr_t;
	typedef logic [word_w-1:0]     word_t;
	typedef logic [imm_w-1:0]      imm16_t;

	////////////////////////////////////////
	// opcodes
	////////////////////////////////////////

	// primary opcode, bits 31:26
	typedef enum logic [op_w-1:0] {
		OP_SPECIAL = 6'b000000,
		OP_ADDI    = 6'b001000,
		OP_ADDIU   = 6'b001001,
		OP_SLTI    = 6'b001010,
		OP_SLTIU   = 6'b001011,
		OP_ANDI    = 6'b001100,
		OP_ORI     = 6'b001101,
		OP_XORI    = 6'b001110,
		OP_LUI     = 6'b001111
	} opcode_e;

	// function field of SPECIAL, bits 5:0
	typedef enum logic [op_w-1:0] {
		FN_SLL  = 6'b000000,
		FN_SRL  = 6'b000010,
		FN_SRA  = 6'b000011,
		FN_SLLV = 6'b000100,
		FN_SRLV = 6'b000110,
		FN_SRAV = 6'b000111,
		FN_ADD  = 6'b100000,
		FN_ADDU = 6'b100001,
		FN_SUB  = 6'b100010,
		FN_SUBU = 6'b100011,
		FN_AND  = 6'b100100,
		FN_OR   = 6'b100101,
		FN_XOR  = 6'b100110,
		FN_NOR  = 6'b100111,
		FN_SLT  = 6'b101010,
		FN_SLTU = 6'b101011
	} funct_e;

	// R-type layout; for I-type the low 16 bits are the immediate
	typedef struct packed {
		opcode_e              opcode;
		reg_addr_t            rs;
		reg_addr_t            rt;
		reg_addr_t            rd;
		logic [shamt_w-1:0]   shamt;
		funct_e               funct;
	} inst_t;

endpackage

// ==== design/operand_select.sv ====
`timescale 1ns/1ps

module operand_select (
	input  logic               read_i,
	input  isa_pkg::reg_addr_t addr_i,
	input  isa_pkg::word_t     reg_data_i,
	input  isa_pkg::word_t     imm_i,
	input  pipe_pkg::fwd_t     ex_fwd_i,
	input  pipe_pkg::fwd_t     mem_fwd_i,
	output isa_pkg::word_t     operand_o
);

	logic ex_hit;
	logic mem_hit;

	// a forward only counts if it is about to write this register
	assign ex_hit  = ex_fwd_i.we && (ex_fwd_i.waddr == addr_i);
	assign mem_hit = mem_fwd_i.we && (mem_fwd_i.waddr == addr_i);

	always_comb begin
		if (!read_i) begin
			operand_o = imm_i;
		end else if (ex_hit) begin
			// youngest result wins
			operand_o = ex_fwd_i.wdata;
		end else if (mem_hit) begin
			operand_o = mem_fwd_i.wdata;
		end else begin
			operand_o = reg_data_i;
		end
	end

endmodule

// ==== design/pipe_pkg.sv ====
package pipe_pkg;

	////////////////////////////////////////
	// ALU control
	////////////////////////////////////////
	typedef enum logic [2:0] {
		SEL_NOP   = 3'b000,
		SEL_LOGIC = 3'b001,
		SEL_SHIFT = 3'b010,
		SEL_ARITH = 3'b100
	} alusel_e;

	typedef enum logic [7:0] {
		ALU_NOP   = 8'h00,
		// logic group
		ALU_ANDI  = 8'h0c,
		ALU_ORI   = 8'h0d,
		ALU_XORI  = 8'h0e,
		ALU_LUI   = 8'h0f,
		ALU_AND   = 8'h24,
		ALU_OR    = 8'h25,
		ALU_XOR   = 8'h26,
		ALU_NOR   = 8'h27,
		// shift group, sll funct is zero so bit 6 keeps it apart from NOP
		ALU_SLL   = 8'h40,
		ALU_SRL   = 8'h02,
		ALU_SRA   = 8'h03,
		ALU_SLLV  = 8'h04,
		ALU_SRLV  = 8'h06,
		ALU_SRAV  = 8'h07,
		// arithmetic group
		ALU_ADDI  = 8'h08,
		ALU_ADDIU = 8'h09,
		ALU_SLTI  = 8'h0a,
		ALU_SLTIU = 8'h0b,
		ALU_ADD   = 8'h20,
		ALU_ADDU  = 8'h21,
		ALU_SUB   = 8'h22,
		ALU_SUBU  = 8'h23,
		ALU_SLT   = 8'h2a,
		ALU_SLTU  = 8'h2b
	} aluop_e;

	////////////////////////////////////////
	// bundles
	////////////////////////////////////////

	// result in flight, also used as the writeback port
	typedef struct packed {
		logic               we;
		isa_pkg::reg_addr_t waddr;
		isa_pkg::word_t     wdata;
	} fwd_t;

	typedef struct packed {
		aluop_e             aluop;
		alusel_e            alusel;
		logic               wreg;
		isa_pkg::reg_addr_t waddr;
		logic               rs_read;
		isa_pkg::reg_addr_t rs_addr;
		logic               rt_read;
		isa_pkg::reg_addr_t rt_addr;
		isa_pkg::word_t     imm;
	} dec_t;

	typedef struct packed {
		logic               valid;
		aluop_e             aluop;
		alusel_e            alusel;
		logic               wreg;
		isa_pkg::reg_addr_t waddr;
		isa_pkg::word_t     op1;
		isa_pkg::word_t     op2;
	} id_ex_t;

endpackage

// ==== design/regfile.sv ====
`timescale 1ns/1ps

module regfile (
	input  logic               clk,
	input  logic               reset_n,
	input  pipe_pkg::fwd_t     wb_i,
	input  isa_pkg::reg_addr_t rs_addr_i,
	input  isa_pkg::reg_addr_t rt_addr_i,
	output isa_pkg::word_t     rs_data_o,
	output isa_pkg::word_t     rt_data_o
);

	isa_pkg::word_t regs [isa_pkg::reg_count];

	////////////////////////////////////////
	// write port
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int i = 0; i < isa_pkg::reg_count; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_i.we && (wb_i.waddr != '0)) begin
			regs[wb_i.waddr] <= wb_i.wdata;
		end
	end

	////////////////////////////////////////
	// read ports
	////////////////////////////////////////

	// no bypass here, a same cycle read sees the old word
	assign rs_data_o = (rs_addr_i == '0) ? '0 : regs[rs_addr_i];
	assign rt_data_o = (rt_addr_i == '0) ? '0 : regs[rt_addr_i];

endmodule

// ==== include/id_ref_model.svh ====
`ifndef ID_REF_MODEL_SVH
`define ID_REF_MODEL_SVH

// shadow register file, fed from the same writeback traffic
isa_pkg::word_t ref_regs [isa_pkg::reg_count];

function automatic void ref_reset();
	foreach (ref_regs[i]) begin
		ref_regs[i] = '0;
	end
endfunction

function automatic void ref_write(input pipe_pkg::fwd_t wb);
	if (wb.we && (wb.waddr != '0)) begin
		ref_regs[wb.waddr] = wb.wdata;
	end
endfunction

// execute forward, then memory forward, then the shadow file
function automatic isa_pkg::word_t ref_operand(
	input logic               rd,
	input isa_pkg::reg_addr_t addr,
	input isa_pkg::word_t     imm,
	input pipe_pkg::fwd_t     ex,
	input pipe_pkg::fwd_t     mem
);
	if (!rd) begin
		return imm;
	end
	if (ex.we && (ex.waddr == addr)) begin
		return ex.wdata;
	end
	if (mem.we && (mem.waddr == addr)) begin
		return mem.wdata;
	end
	return ref_regs[addr];
endfunction

// expected decode/execute bundle for one presented instruction
function automatic pipe_pkg::id_ex_t ref_expect(
	input logic           valid,
	input isa_pkg::inst_t inst,
	input pipe_pkg::fwd_t ex,
	input pipe_pkg::fwd_t mem
);
	pipe_pkg::id_ex_t e;
	logic             rs_rd;
	logic             rt_rd;
	isa_pkg::word_t   imm;
	e     = '0;
	rs_rd = 1'b0;
	rt_rd = 1'b0;
	imm   = '0;
	if (inst.opcode == isa_pkg::OP_SPECIAL) begin
		e.waddr = inst.rd;
		rs_rd   = 1'b1;
		rt_rd   = 1'b1;
		e.aluop = (inst.funct == isa_pkg::FN_SLL) ? pipe_pkg::ALU_SLL :
			pipe_pkg::aluop_e'({2'b00, inst.funct});
		case (inst.funct)
			isa_pkg::FN_SLL, isa_pkg::FN_SRL, isa_pkg::FN_SRA: begin
				e.alusel = pipe_pkg::SEL_SHIFT;
				rs_rd    = 1'b0;
				imm      = {27'd0, inst.shamt};
			end
			isa_pkg::FN_SLLV, isa_pkg::FN_SRLV, isa_pkg::FN_SRAV:
				e.alusel = pipe_pkg::SEL_SHIFT;
			isa_pkg::FN_AND, isa_pkg::FN_OR, isa_pkg::FN_XOR, isa_pkg::FN_NOR:
				e.alusel = pipe_pkg::SEL_LOGIC;
			isa_pkg::FN_ADD, isa_pkg::FN_ADDU, isa_pkg::FN_SUB, isa_pkg::FN_SUBU,
			isa_pkg::FN_SLT, isa_pkg::FN_SLTU:
				e.alusel = pipe_pkg::SEL_ARITH;
			default: begin
				rs_rd = 1'b0;
				rt_rd = 1'b0;
			end
		endcase
	end else begin
		e.waddr = inst.rt;
		rs_rd   = 1'b1;
		e.aluop = pipe_pkg::aluop_e'({2'b00, inst.opcode});
		case (inst.opcode)
			isa_pkg::OP_ORI, isa_pkg::OP_ANDI, isa_pkg::OP_XORI, isa_pkg::OP_LUI: begin
				e.alusel = pipe_pkg::SEL_LOGIC;
				imm      = {16'h0000, inst[15:0]};
			end
			isa_pkg::OP_ADDI, isa_pkg::OP_ADDIU, isa_pkg::OP_SLTI, isa_pkg::OP_SLTIU: begin
				e.alusel = pipe_pkg::SEL_ARITH;
				imm      = {{16{inst[15]}}, inst[15:0]};
			end
			default:
				rs_rd = 1'b0;
		endcase
	end
	e.wreg = (e.alusel != pipe_pkg::SEL_NOP);
	e.op1  = ref_operand(rs_rd, inst.rs, imm, ex, mem);
	e.op2  = ref_operand(rt_rd, inst.rt, imm, ex, mem);
	// bubbles and invalid cycles carry no control
	if (!e.wreg || !valid) begin
		e.aluop  = pipe_pkg::ALU_NOP;
		e.alusel = pipe_pkg::SEL_NOP;
		e.wreg   = 1'b0;
		e.waddr  = '0;
	end
	e.valid = valid;
	return e;
endfunction

`endif

// ==== dv/id_stage_tb.sv ====
`timescale 1ns/1ps

module id_stage_tb;

	`include "id_ref_model.svh"

	localparam int n_preload = 33;
	localparam int n_direct  = 30;
	localparam int n_random  = 300;
	localparam int limit     = (n_preload + n_direct + n_random + 3) * 2 + 50;

	logic             clk;
	logic             reset_n;
	logic             inst_valid;
	isa_pkg::inst_t   inst;
	pipe_pkg::fwd_t   ex_fwd;
	pipe_pkg::fwd_t   mem_fwd;
	pipe_pkg::fwd_t   wb;
	logic             stall;
	pipe_pkg::id_ex_t id_ex;

	pipe_pkg::id_ex_t exp_q[$];
	pipe_pkg::id_ex_t held;
	integer           seed;
	int               errors;
	int               checks;
	int               cycles;

	isa_pkg::opcode_e i_ops [8] = '{isa_pkg::OP_ORI, isa_pkg::OP_ANDI, isa_pkg::OP_XORI,
		isa_pkg::OP_LUI, isa_pkg::OP_ADDI, isa_pkg::OP_ADDIU, isa_pkg::OP_SLTI,
		isa_pkg::OP_SLTIU};
	isa_pkg::funct_e r_fns [16] = '{isa_pkg::FN_AND, isa_pkg::FN_OR, isa_pkg::FN_XOR,
		isa_pkg::FN_NOR, isa_pkg::FN_SLL, isa_pkg::FN_SRL, isa_pkg::FN_SRA,
		isa_pkg::FN_SLLV, isa_pkg::FN_SRLV, isa_pkg::FN_SRAV, isa_pkg::FN_ADD,
		isa_pkg::FN_ADDU, isa_pkg::FN_SUB, isa_pkg::FN_SUBU, isa_pkg::FN_SLT,
		isa_pkg::FN_SLTU};
	// mult, multu, movz, mfhi
	logic [5:0] bad_fns [4] = '{6'h18, 6'h19, 6'h0a, 6'h10};

	id_stage UUT (
		.clk          (clk),
		.reset_n      (reset_n),
		.inst_valid_i (inst_valid),
		.inst_i       (inst),
		.ex_fwd_i     (ex_fwd),
		.mem_fwd_i    (mem_fwd),
		.wb_i         (wb),
		.stall_i      (stall),
		.id_ex_o      (id_ex)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#2 clk = ~clk;
		end
	end

	////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////
	task automatic check_word(input string name, input isa_pkg::word_t exp,
			input isa_pkg::word_t act);
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %s expected %h actual %h at %0t", name, exp, act, $time);
		end
	endtask

	task automatic check_bundle(input pipe_pkg::id_ex_t exp, input pipe_pkg::id_ex_t act);
		checks++;
		if (act.valid !== exp.valid || act.wreg !== exp.wreg || act.waddr !== exp.waddr) begin
			errors++;
			$display("[ERROR] id_ex_o valid/wreg/waddr expected %h/%h/%h actual %h/%h/%h",
				exp.valid, exp.wreg, exp.waddr, act.valid, act.wreg, act.waddr);
		end
		if (act.aluop !== exp.aluop || act.alusel !== exp.alusel) begin
			errors++;
			$display("[ERROR] id_ex_o aluop/alusel expected %h/%h actual %h/%h",
				exp.aluop, exp.alusel, act.aluop, act.alusel);
		end
		check_word("id_ex_o.op1", exp.op1, act.op1);
		check_word("id_ex_o.op2", exp.op2, act.op2);
	endtask

	////////////////////////////////////////
	// stimulus helpers
	////////////////////////////////////////

	// forward that hits rs, rt or a random register
	function automatic pipe_pkg::fwd_t rand_fwd(input isa_pkg::inst_t in);
		pipe_pkg::fwd_t f;
		int             r;
		int             pick;
		r       = $random(seed);
		pick    = $unsigned($random(seed)) % 3;
		f.we    = r[0];
		f.wdata = $random(seed);
		f.waddr = (pick == 0) ? in.rs : (pick == 1) ? in.rt : r[8:4];
		return f;
	endfunction

	task automatic run_cycle(input logic valid, input isa_pkg::inst_t in,
			input pipe_pkg::fwd_t ex, input pipe_pkg::fwd_t mem,
			input pipe_pkg::fwd_t w, input logic hold);
		@(negedge clk);
		reset_n    = 1'b1;
		inst_valid = valid;
		inst       = in;
		ex_fwd     = ex;
		mem_fwd    = mem;
		wb         = w;
		stall      = hold;
		// the write lands at the same edge, so the read sees the old value
		if (!hold) begin
			held = ref_expect(valid, in, ex, mem);
		end
		exp_q.push_back(held);
		ref_write(w);
	endtask

	// occasional stall cycles, then the same instruction again
	task automatic issue(input logic valid, input isa_pkg::inst_t in,
			input pipe_pkg::fwd_t ex, input pipe_pkg::fwd_t mem);
		while (($random(seed) & 7) == 0) begin
			run_cycle(valid, in, ex, mem, rand_fwd(in), 1'b1);
		end
		run_cycle(valid, in, ex, mem, rand_fwd(in), 1'b0);
	endtask

	initial begin
		cycles = 0;
		while (cycles <= limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: the run did not finish within %0d cycles", limit);
		$display("Checks failed");
		$finish;
	end

	initial begin
		pipe_pkg::id_ex_t exp;
		forever begin
			@(posedge clk);
			#1;
			if (exp_q.size() > 0) begin
				exp = exp_q.pop_front();
				check_bundle(exp, id_ex);
			end
		end
	end

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////
	initial begin
		isa_pkg::inst_t in;
		pipe_pkg::fwd_t w;
		int             kind;
		seed       = 32'he858;
		errors     = 0;
		checks     = 0;
		reset_n    = 1'b0;
		inst_valid = 1'b0;
		inst       = '0;
		ex_fwd     = '0;
		mem_fwd    = '0;
		wb         = '0;
		stall      = 1'b0;
		held       = '0;
		ref_reset();
		repeat (2) begin
			@(negedge clk);
			exp_q.push_back('0);
		end

		// bubble first, then fill every register with invalid cycles
		run_cycle(1'b0, '0, '0, '0, '0, 1'b0);
		for (int i = 0; i < n_preload - 1; i++) begin
			in      = $random(seed);
			w.we    = 1'b1;
			w.waddr = i[4:0];
			w.wdata = $random(seed);
			run_cycle(1'b0, in, '0, '0, w, 1'b0);
		end

		// each kept op once with immediates of both signs
		for (int i = 0; i < 8; i++) begin
			in           = $random(seed);
			in.opcode    = i_ops[i];
			in[15]       = i[0];
			issue(1'b1, in, '0, '0);
		end
		for (int i = 0; i < 16; i++) begin
			in        = $random(seed);
			in.opcode = isa_pkg::OP_SPECIAL;
			in.funct  = r_fns[i];
			issue(1'b1, in, '0, '0);
		end
		for (int i = 0; i < 4; i++) begin
			in        = $random(seed);
			in.opcode = isa_pkg::OP_SPECIAL;
			in.funct  = isa_pkg::funct_e'(bad_fns[i]);
			issue(1'b1, in, '0, '0);
		end
		// SPECIAL2 and a load
		in        = $random(seed);
		in.opcode = isa_pkg::opcode_e'(6'h1c);
		issue(1'b1, in, '0, '0);
		in.opcode = isa_pkg::opcode_e'(6'h23);
		issue(1'b1, in, '0, '0);

		for (int n = 0; n < n_random; n++) begin
			in   = $random(seed);
			kind = $unsigned($random(seed)) % 10;
			if (kind < 4) begin
				in.opcode = i_ops[kind * 2 + (n & 1)];
			end else if (kind < 9) begin
				in.opcode = isa_pkg::OP_SPECIAL;
				in.funct  = r_fns[$unsigned($random(seed)) % 16];
			end else begin
				in.opcode = isa_pkg::OP_SPECIAL;
				in.funct  = isa_pkg::funct_e'(bad_fns[n % 4]);
			end
			issue(($random(seed) & 7) != 0, in, rand_fwd(in), rand_fwd(in));
		end

		wait (exp_q.size() == 0);
		#2;
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// ==== id_stage.f ====
+incdir+include
design/isa_pkg.sv
design/pipe_pkg.sv
design/inst_decoder.sv
design/operand_select.sv
design/regfile.sv
design/id_ex_reg.sv
design/id_stage.sv
dv/id_stage_tb.sv
